// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= decodeUnitTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?=

SOURCES := $(wildcard verilog/*.sv test/*.sv test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim.f ====
+incdir+test
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/instrClassifier.sv
verilog/decodeQueue.sv
verilog/controlGenerator.sv
verilog/decodeUnit.sv
test/decodeUnitTb.sv

// ==== test/decodeModel.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

logic [31:0] lfsrState;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] takeBits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
        feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        value     = {value[30:0], feedback}; // one step per bit handed out
    end
    return value;
endfunction

// expected {illegal, control word} straight from the instruction bits
function automatic logic [31:0] expectedDecode(input instrWord_t word);
    controlWord_t cw;
    logic         illegal;
    logic [5:0]   opcode;
    logic [5:0]   funct;
    cw      = '0;
    illegal = 1'b0;
    opcode  = word[31:26];
    funct   = word[5:0];
    if (word != '0) begin
        case (opcode)
            6'b000000: begin // r-type
                if (funct == 6'b100001 || funct == 6'b100011) begin
                    cw.sourceOperand = SRC_REG;
                    cw.aluOp         = (funct == 6'b100011) ? ALU_SUB : ALU_ADD;
                    cw.rfEnable      = 1'b1;
                    cw.destination   = DEST_RD;
                end else if (funct == 6'b001000) begin
                    cw.branchOrJump = 1'b1; // jr
                    cw.jump         = 1'b1;
                    cw.rsAddrMux    = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            6'b001001, 6'b100100: begin // addiu and lbu
                cw.sourceOperand = SRC_IMM;
                cw.aluOp         = ALU_ADD;
                cw.rfEnable      = 1'b1;
                cw.destination   = DEST_RT;
                cw.loadInstr     = opcode[5];
                cw.memEnable     = opcode[5];
            end
            6'b000111: begin // bgtz
                cw.aluOp           = ALU_BRANCH_CMP;
                cw.branchInstr     = 1'b1;
                cw.targetAddrInstr = 1'b1;
                cw.rsAddrMux       = 1'b1;
            end
            6'b000011: begin // jal
                cw.sourceOperand   = SRC_LINK;
                cw.aluOp           = ALU_LINK;
                cw.rfEnable        = 1'b1;
                cw.targetAddrInstr = 1'b1;
                cw.branchOrJump    = 1'b1;
                cw.jump            = 1'b1;
                cw.destination     = DEST_R31;
            end
            6'b001111: begin // lui
                cw.sourceOperand = SRC_UPPER_IMM;
                cw.aluOp         = ALU_UPPER;
                cw.rfEnable      = 1'b1;
                cw.destination   = DEST_RT;
            end
            6'b101000: begin // sb
                cw.memWrite  = 1'b1;
                cw.memEnable = 1'b1;
            end
            6'b000001, 6'b000100: begin // regimm group and beq
                cw.aluOp           = (opcode == 6'b000001) ? ALU_BRANCH_CMP : ALU_ADD;
                cw.branchInstr     = 1'b1;
                cw.targetAddrInstr = 1'b1;
                cw.branchOrJump    = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end
    return {7'd0, illegal, cw};
endfunction

// stops the run at the first mismatch
task automatic checkValue(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        stopOnFailure();
    end
endtask

`endif

// ==== test/decodeUnitTb.sv ====
`timescale 1ns/1ps

module decodeUnitTb import isaPkg::*, ctrlPkg::*; ();

    localparam int HALF_PERIOD     = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_ITEMS  = 16;
    localparam int RANDOM_ITEMS    = 300;
    localparam int STALL_ITEMS     = 8;
    localparam int CYCLES_PER_ITEM = 40;
    localparam int WATCH_CYCLES    = RESET_CYCLES
        + CYCLES_PER_ITEM * (DIRECTED_ITEMS + RANDOM_ITEMS + STALL_ITEMS);
    localparam int PIPE_CAPACITY   = QUEUE_DEPTH + 2; // plus classifier and generator
    localparam logic [31:0] SEED   = 32'h3aa831f8;

    // one of each kept class, then zero and illegal words
    localparam logic [31:0] DIRECTED_WORDS [DIRECTED_ITEMS] = '{
        32'h2485_1234, 32'h0123_4823, 32'h0123_4821, 32'h9085_0004,
        32'h1C80_0010, 32'h0C10_0040, 32'h3C01_ABCD, 32'h03E0_0008,
        32'hA085_0003, 32'h0481_0008, 32'h1000_FFFF, 32'h0000_0000,
        32'hFC00_0000, 32'h0123_4820, 32'h2001_0005, 32'h0001_0840
    };

    logic         clk;
    logic         reset;
    logic         inValid;
    logic         inReady;
    instrWord_t   inWord;
    logic         outValid;
    logic         outReady;
    controlWord_t outControl;
    logic         outIllegal;

    logic         inTaken;           // word accepted at the last rising edge
    int           acceptCount = 0;
    int           receivedCount = 0;
    instrWord_t   wordQueue [$];     // accepted, not yet out

    task automatic stopOnFailure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    `include "decodeModel.svh"

    decodeUnit i_decodeUnit (
        .clk        (clk),
        .reset      (reset),
        .inValid    (inValid),
        .inReady    (inReady),
        .inWord     (inWord),
        .outValid   (outValid),
        .outReady   (outReady),
        .outControl (outControl),
        .outIllegal (outIllegal)
    );

    always #HALF_PERIOD clk = ~clk;

    // both handshakes seen with pre-edge values
    always @(posedge clk) begin
        instrWord_t sentWord;
        inTaken = 1'b0;
        if (!reset) begin
            if (inValid && inReady) begin
                inTaken = 1'b1;
                wordQueue.push_back(inWord);
                acceptCount++;
            end
            if (outValid && outReady) begin
                if (wordQueue.size() == 0) begin
                    $display("output transfer with no word outstanding");
                    stopOnFailure();
                end else begin
                    sentWord = wordQueue.pop_front();
                    checkValue($sformatf("decode of %h", sentWord), expectedDecode(sentWord),
                               {7'd0, outIllegal, outControl});
                    receivedCount++;
                end
            end
        end
    end

    function automatic instrWord_t randomWord();
        logic [31:0] kind;
        logic [31:0] bits;
        kind = takeBits(4);
        bits = takeBits(26);
        case (kind[3:0])
            4'd0:    return '0;
            4'd1:    return {6'b001001, bits[25:0]};
            4'd2:    return {6'b000000, bits[25:6], 6'b100011};
            4'd3:    return {6'b000000, bits[25:6], 6'b100001};
            4'd4:    return {6'b100100, bits[25:0]};
            4'd5:    return {6'b000111, bits[25:0]};
            4'd6:    return {6'b000011, bits[25:0]};
            4'd7:    return {6'b001111, bits[25:0]};
            4'd8:    return {6'b000000, bits[25:6], 6'b001000};
            4'd9:    return {6'b101000, bits[25:0]};
            4'd10:   return {6'b000001, bits[25:0]};
            4'd11:   return {6'b000100, bits[25:0]};
            4'd12:   return {6'b000000, bits[25:0]}; // any funct
            default: return takeBits(32);
        endcase
    endfunction

    // offer one word, hold it until taken
    task automatic sendWord(input instrWord_t word, input logic randomTiming);
        while (randomTiming && takeBits(2) == 32'd0) begin
            @(negedge clk);
            outReady = takeBits(2) != 32'd0;
        end
        inWord  = word;
        inValid = 1'b1;
        do begin
            @(negedge clk);
            outReady = randomTiming ? (takeBits(2) != 32'd0) : 1'b1;
        end while (!inTaken);
        inValid = 1'b0;
    endtask

    task automatic drainOutputs();
        while (receivedCount != acceptCount) begin
            @(negedge clk);
            outReady = 1'b1;
        end
    endtask

    // fill the empty pipe with outReady low, then let it go
    task automatic stallAndRelease();
        int startCount;
        int cycles;
        startCount = acceptCount;
        cycles     = 0;
        outReady   = 1'b0;
        inWord     = randomWord();
        inValid    = 1'b1;
        while (inReady) begin
            if (cycles > 4 * PIPE_CAPACITY) begin
                $display("inReady stayed high while outReady was held low");
                stopOnFailure();
            end
            @(negedge clk);
            if (inTaken) begin
                inWord = randomWord();
            end
            cycles++;
        end
        checkValue("stall depth", PIPE_CAPACITY, acceptCount - startCount);
        do begin
            @(negedge clk);
            outReady = takeBits(1) != 32'd0; // the waiting word still offered
        end while (!inTaken);
        inValid = 1'b0;
        drainOutputs();
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        inValid   = 1'b0;
        inWord    = '0;
        outReady  = 1'b0;
        lfsrState = SEED;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        checkValue("reset outValid", 32'd0, {31'd0, outValid});
        checkValue("reset inReady", 32'd1, {31'd0, inReady});

        outReady = 1'b1;
        for (int i = 0; i < DIRECTED_ITEMS; i++) begin
            sendWord(DIRECTED_WORDS[i], 1'b0);
        end
        drainOutputs();

        for (int n = 0; n < RANDOM_ITEMS; n++) begin
            sendWord(randomWord(), 1'b1); // gaps and back-pressure
        end
        drainOutputs();

        stallAndRelease();

        // a leftover or repeated item would keep outValid up
        if (outValid) begin
            $display("outValid still high after every accepted word came out");
            stopOnFailure();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles with %0d of %0d outputs seen",
                 WATCH_CYCLES, receivedCount, acceptCount);
        stopOnFailure();
    end

endmodule

// ==== verilog/controlGenerator.sv ====
`timescale 1ns/1ps

module controlGenerator import isaPkg::*, ctrlPkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         qValid,
    output logic         qReady,
    input  instrClass_t  qClass,
    output logic         outValid,
    input  logic         outReady,
    output controlWord_t outControl,
    output logic         outIllegal
);

    controlWord_t nextControl;
    logic         accept;

    assign qReady = !outValid || outReady;
    assign accept = qValid && qReady;

    always_comb begin
        nextControl = '0; // nop and illegal keep this
        case (qClass)
            CLS_ADDIU: begin
                nextControl.sourceOperand = SRC_IMM;
                nextControl.aluOp         = ALU_ADD;
                nextControl.rfEnable      = 1'b1;
                nextControl.destination   = DEST_RT;
            end
            CLS_SUBU: begin
                nextControl.sourceOperand = SRC_REG;
                nextControl.aluOp         = ALU_SUB;
                nextControl.rfEnable      = 1'b1;
                nextControl.destination   = DEST_RD;
            end
            CLS_ADDU: begin
                nextControl.sourceOperand = SRC_REG;
                nextControl.aluOp         = ALU_ADD;
                nextControl.rfEnable      = 1'b1;
                nextControl.destination   = DEST_RD;
            end
            CLS_LBU: begin
                nextControl.sourceOperand = SRC_IMM; // base + offset
                nextControl.aluOp         = ALU_ADD;
                nextControl.loadInstr     = 1'b1;
                nextControl.rfEnable      = 1'b1;
                nextControl.memEnable     = 1'b1; // byte, zero extended
                nextControl.destination   = DEST_RT;
            end
            CLS_BGTZ: begin
                nextControl.aluOp           = ALU_BRANCH_CMP;
                nextControl.branchInstr     = 1'b1;
                nextControl.targetAddrInstr = 1'b1;
                nextControl.rsAddrMux       = 1'b1;
            end
            CLS_JAL: begin
                nextControl.sourceOperand   = SRC_LINK;
                nextControl.aluOp           = ALU_LINK;
                nextControl.rfEnable        = 1'b1;
                nextControl.targetAddrInstr = 1'b1;
                nextControl.branchOrJump    = 1'b1;
                nextControl.jump            = 1'b1;
                nextControl.destination     = DEST_R31;
            end
            CLS_LUI: begin
                nextControl.sourceOperand = SRC_UPPER_IMM;
                nextControl.aluOp         = ALU_UPPER;
                nextControl.rfEnable      = 1'b1;
                nextControl.destination   = DEST_RT;
            end
            CLS_JR: begin
                nextControl.branchOrJump = 1'b1;
                nextControl.jump         = 1'b1;
                nextControl.rsAddrMux    = 1'b1; // target from rs
            end
            CLS_SB: begin
                nextControl.memWrite  = 1'b1;
                nextControl.memEnable = 1'b1;
            end
            CLS_REGIMM: begin
                nextControl.aluOp           = ALU_BRANCH_CMP;
                nextControl.branchInstr     = 1'b1;
                nextControl.targetAddrInstr = 1'b1;
                nextControl.branchOrJump    = 1'b1;
            end
            CLS_BEQ: begin
                nextControl.branchInstr     = 1'b1;
                nextControl.targetAddrInstr = 1'b1;
                nextControl.branchOrJump    = 1'b1;
            end
            default: nextControl = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (accept) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outControl <= nextControl;
            outIllegal <= qClass == CLS_ILLEGAL;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        outValid && !outReady |=> outValid && $stable(outControl) && $stable(outIllegal));

endmodule

// ==== verilog/ctrlPkg.sv ====
package ctrlPkg;

    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef enum logic [3:0] {
        ALU_ADD        = 4'b0000,
        ALU_SUB        = 4'b0001,
        ALU_BRANCH_CMP = 4'b1010,
        ALU_UPPER      = 4'b1011, // lui shift
        ALU_LINK       = 4'b1100  // pc + 8 for jal
    } aluOp_t;

    typedef enum logic [2:0] {
        SRC_REG       = 3'b000,
        SRC_LINK      = 3'b011,
        SRC_IMM       = 3'b100,
        SRC_UPPER_IMM = 3'b101
    } srcOperand_t;

    typedef enum logic [1:0] {
        DEST_NONE = 2'b00,
        DEST_RD   = 2'b01,
        DEST_RT   = 2'b10,
        DEST_R31  = 2'b11
    } destReg_t;

    // 24 bits, msb first, same layout the datapath expects
    typedef struct packed {
        logic        addrMux;         // bit 23
        logic        rsAddrMux;
        logic        branchOrJump;
        logic        jump;            // bit 20
        destReg_t    destination;
        srcOperand_t sourceOperand;
        aluOp_t      aluOp;
        logic        branchInstr;     // bit 10
        logic        loadInstr;
        logic        rfEnable;
        logic        targetAddrInstr;
        logic [1:0]  memSize;
        logic        memWrite;
        logic        memSignExtend;
        logic        memEnable;
        logic        hiEnable;
        logic        loEnable;        // bit 0
    } controlWord_t;

endpackage

// ==== verilog/decodeQueue.sv ====
`timescale 1ns/1ps

module decodeQueue import isaPkg::*, ctrlPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        clsValid,
    output logic        clsReady,
    input  instrClass_t clsClass,
    output logic        qValid,
    input  logic        qReady,
    output instrClass_t qClass
);

    instrClass_t            mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wrPtr;
    logic [QUEUE_PTR_W-1:0] rdPtr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   doWrite;
    logic                   doRead;

    function automatic logic [QUEUE_PTR_W-1:0] nextPtr(input logic [QUEUE_PTR_W-1:0] ptr);
        if (ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign clsReady = count != QUEUE_CNT_W'(QUEUE_DEPTH); // not full
    assign qValid   = count != '0;
    assign qClass   = mem[rdPtr];
    assign doWrite  = clsValid && clsReady;
    assign doRead   = qValid && qReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doRead) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= clsClass;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        count <= QUEUE_CNT_W'(QUEUE_DEPTH));

    // equal pointers mean empty unless the count says full
    assert property (@(posedge clk) disable iff (reset)
        doRead |-> (rdPtr != wrPtr) || (count == QUEUE_CNT_W'(QUEUE_DEPTH)));

endmodule

// ==== verilog/decodeUnit.sv ====
`timescale 1ns/1ps

module decodeUnit import isaPkg::*, ctrlPkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         inValid,
    output logic         inReady,
    input  instrWord_t   inWord,
    output logic         outValid,
    input  logic         outReady,
    output controlWord_t outControl,
    output logic         outIllegal
);

    logic        clsValid;
    logic        clsReady;
    instrClass_t clsClass;
    logic        qValid;
    logic        qReady;
    instrClass_t qClass;

    instrClassifier i_instrClassifier (
        .clk      (clk),
        .reset    (reset),
        .inValid  (inValid),
        .inReady  (inReady),
        .inWord   (inWord),
        .clsValid (clsValid),
        .clsReady (clsReady),
        .clsClass (clsClass)
    );

    decodeQueue i_decodeQueue (
        .clk      (clk),
        .reset    (reset),
        .clsValid (clsValid),
        .clsReady (clsReady),
        .clsClass (clsClass),
        .qValid   (qValid),
        .qReady   (qReady),
        .qClass   (qClass)
    );

    controlGenerator i_controlGenerator (
        .clk        (clk),
        .reset      (reset),
        .qValid     (qValid),
        .qReady     (qReady),
        .qClass     (qClass),
        .outValid   (outValid),
        .outReady   (outReady),
        .outControl (outControl),
        .outIllegal (outIllegal)
    );

endmodule

// ==== verilog/instrClassifier.sv ====
`timescale 1ns/1ps

module instrClassifier import isaPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        inValid,
    output logic        inReady,
    input  instrWord_t  inWord,
    output logic        clsValid,
    input  logic        clsReady,
    output instrClass_t clsClass
);

    rFields_t    fields;
    instrClass_t nextClass;
    logic        accept;

    assign inReady = !clsValid || clsReady; // empty or draining this cycle
    assign accept  = inValid && inReady;

    always_comb begin
        fields    = rFields_t'(inWord);
        nextClass = CLS_ILLEGAL;
        if (inWord == '0) begin
            nextClass = CLS_NOP; // sll r0 would decode as special otherwise
        end else begin
            case (fields.opcode)
                OP_SPECIAL: begin
                    case (fields.funct)
                        FN_ADDU: nextClass = CLS_ADDU;
                        FN_SUBU: nextClass = CLS_SUBU;
                        FN_JR:   nextClass = CLS_JR;
                        default: nextClass = CLS_ILLEGAL;
                    endcase
                end
                OP_REGIMM: nextClass = CLS_REGIMM;
                OP_JAL:    nextClass = CLS_JAL;
                OP_BEQ:    nextClass = CLS_BEQ;
                OP_BGTZ:   nextClass = CLS_BGTZ;
                OP_ADDIU:  nextClass = CLS_ADDIU;
                OP_LUI:    nextClass = CLS_LUI;
                OP_LBU:    nextClass = CLS_LBU;
                OP_SB:     nextClass = CLS_SB;
                default:   nextClass = CLS_ILLEGAL;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            clsValid <= 1'b0;
        end else if (accept) begin
            clsValid <= 1'b1;
        end else if (clsReady) begin
            clsValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            clsClass <= nextClass;
        end
    end

    // class must wait for the queue untouched
    assert property (@(posedge clk) disable iff (reset)
        clsValid && !clsReady |=> clsValid && $stable(clsClass));

endmodule

// ==== verilog/isaPkg.sv ====
package isaPkg;

    localparam int WORD_W   = 32;
    localparam int OPCODE_W = 6;
    localparam int REG_W    = 5; // rs, rt, rd and shamt
    localparam int FUNCT_W  = 6;
    localparam int CLASS_W  = 4;

    typedef logic [WORD_W-1:0] instrWord_t;

    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL = 6'b000000, // R-type, resolved by funct
        OP_REGIMM  = 6'b000001, // branch group, rt not decoded
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100, // also B when rs == rt
        OP_BGTZ    = 6'b000111,
        OP_ADDIU   = 6'b001001,
        OP_LUI     = 6'b001111,
        OP_LBU     = 6'b100100,
        OP_SB      = 6'b101000
    } opcode_t;

    typedef enum logic [FUNCT_W-1:0] {
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011
    } funct_t;

    // field view of an R-type word
    typedef struct packed {
        opcode_t           opcode;
        logic [REG_W-1:0]  rs;
        logic [REG_W-1:0]  rt;
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  shamt;
        funct_t            funct;
    } rFields_t;

    typedef enum logic [CLASS_W-1:0] {
        CLS_NOP, CLS_ADDIU, CLS_SUBU, CLS_ADDU,
        CLS_LBU, CLS_BGTZ, CLS_JAL, CLS_LUI,
        CLS_JR, CLS_SB, CLS_REGIMM, CLS_BEQ,
        CLS_ILLEGAL
    } instrClass_t;

endpackage
